// ==== src/rob_pkg.sv ====
package rob_pkg;

    // machine widths
    parameter int LANES             = 3;   // dispatch / complete / retire width
    parameter int ARCH_REG_BITS     = 5;   // architectural register index
    parameter int XLEN              = 32;  // result word
    parameter int DEFAULT_ROB_DEPTH = 32;  // entry count, keep a power of two

    typedef logic [ARCH_REG_BITS-1:0] reg_idx_t;
    typedef logic [XLEN-1:0]          word_t;

    // 0..LANES, so two bits while LANES is 3
    typedef logic [1:0] lane_cnt_t;

    // one reorder buffer slot
    typedef struct packed {
        logic     busy;         // allocated, not yet retired
        logic     done;         // result came back on the cdb
        reg_idx_t dest_reg;     // 0 when no destination
        logic     is_mem;       // load or store
        logic     take_branch;  // resolved taken
        word_t    value;        // result
    } rob_entry_t;

endpackage

// ==== src/rob_ifs.sv ====
`timescale 1ns/1ps

// dispatch allocator to entry table
interface alloc_if #(
    parameter int ROB_DEPTH = rob_pkg::DEFAULT_ROB_DEPTH,
    localparam int TAG_W    = $clog2(ROB_DEPTH)
);
    import rob_pkg::*;

    lane_cnt_t                  alloc_count;  // leading valid lanes this cycle
    rob_entry_t [LANES-1:0]     new_entry;    // lane i lands at tail + i
    logic       [TAG_W-1:0]     tail;         // next free slot

    modport producer (
        output alloc_count,
        output new_entry,
        input  tail
    );

    modport buffer (
        input  alloc_count,
        input  new_entry,
        output tail
    );

endinterface

// entry table to retire selector
// clock and reset only feed the checkers on the consumer side
interface retire_if #(
    parameter int ROB_DEPTH = rob_pkg::DEFAULT_ROB_DEPTH,
    localparam int TAG_W    = $clog2(ROB_DEPTH)
) (
    input logic clock,
    input logic arst_n
);
    import rob_pkg::*;

    logic       [TAG_W-1:0] head;          // oldest entry
    rob_entry_t [LANES-1:0] window;        // head, head+1, head+2
    lane_cnt_t              retire_count;  // how many of the window leave

    modport buffer (
        output head,
        output window,
        input  retire_count
    );

    modport consumer (
        input  clock,
        input  arst_n,
        input  head,
        input  window,
        output retire_count
    );

endinterface

// ==== src/rob_dispatch.sv ====
`timescale 1ns/1ps

module rob_dispatch #(
    parameter int ROB_DEPTH = rob_pkg::DEFAULT_ROB_DEPTH,
    localparam int TAG_W    = $clog2(ROB_DEPTH)
) (
    input  logic [rob_pkg::LANES-1:0]                dp_valid,
    input  logic [rob_pkg::LANES-1:0]                dp_dest_valid,
    input  rob_pkg::reg_idx_t [rob_pkg::LANES-1:0]   dp_dest_reg,
    input  logic [rob_pkg::LANES-1:0]                dp_is_mem,

    output logic [rob_pkg::LANES-1:0]                mt_valid,  // to map table
    output logic [rob_pkg::LANES-1:0][TAG_W-1:0]     mt_tag,
    output rob_pkg::reg_idx_t [rob_pkg::LANES-1:0]   mt_reg,

    alloc_if.producer                                ap
);
    import rob_pkg::*;

    // group size = leading valid lanes, first hole ends the group
    always_comb begin
        lane_cnt_t cnt;
        logic      run;
        cnt = '0;
        run = 1'b1;
        for (int i = 0; i < LANES; i++) begin
            run = run & dp_valid[i];
            if (run) begin
                cnt = cnt + 1'b1;
            end
        end
        ap.alloc_count = cnt;
    end

    // new entries, written by the table only below alloc_count
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            ap.new_entry[i].busy        = 1'b1;
            ap.new_entry[i].done        = 1'b0;    // waits for cdb
            ap.new_entry[i].dest_reg    = dp_dest_valid[i] ? dp_dest_reg[i] : '0;
            ap.new_entry[i].is_mem      = dp_is_mem[i];
            ap.new_entry[i].take_branch = 1'b0;    // resolved at completion
            ap.new_entry[i].value       = '0;
        end
    end

    // map table report per lane
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            mt_tag[i]   = ap.tail + TAG_W'(i);     // wraps with depth
            mt_reg[i]   = dp_dest_valid[i] ? dp_dest_reg[i] : '0;
            // lane-local, not gated by the group count
            mt_valid[i] = dp_valid[i] & dp_dest_valid[i];
        end
    end

endmodule

// ==== src/rob_table.sv ====
`timescale 1ns/1ps

module rob_table #(
    parameter int ROB_DEPTH = rob_pkg::DEFAULT_ROB_DEPTH,
    localparam int TAG_W    = $clog2(ROB_DEPTH)
) (
    input  logic                                  clock,
    input  logic                                  arst_n,
    input  logic                                  squash,     // flush everything

    // common data bus
    input  logic [rob_pkg::LANES-1:0]             cdb_valid,
    input  logic [rob_pkg::LANES-1:0][TAG_W-1:0]  cdb_tag,
    input  rob_pkg::word_t [rob_pkg::LANES-1:0]   cdb_value,
    input  logic [rob_pkg::LANES-1:0]             cdb_take_branch,

    output rob_pkg::lane_cnt_t                    free_num,   // capped at LANES

    alloc_if.buffer                               ap,
    retire_if.buffer                              rp
);
    import rob_pkg::*;

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    // control flags, reset
    logic [ROB_DEPTH-1:0] busy;
    logic [ROB_DEPTH-1:0] done;
    logic [TAG_W-1:0]     head;
    logic [TAG_W-1:0]     tail;

    // payload, no reset
    reg_idx_t             ent_reg [ROB_DEPTH];
    word_t                ent_val [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] ent_mem;
    logic [ROB_DEPTH-1:0] ent_br;

    logic [TAG_W-1:0]     hidx [LANES];   // window slots
    logic [TAG_W-1:0]     tidx [LANES];   // allocation slots
    logic [LANES-1:0]     cdb_go;         // leading cdb lanes
    logic [CNT_W-1:0]     idle_cnt;

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            hidx[k] = head + TAG_W'(k);
            tidx[k] = tail + TAG_W'(k);
        end
    end

    // same prefix rule as dispatch, a dropped lane ends the group
    always_comb begin
        logic run;
        run = 1'b1;
        for (int k = 0; k < LANES; k++) begin
            run       = run & cdb_valid[k];
            cdb_go[k] = run;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
            done <= '0;
            head <= '0;
            tail <= '0;
        end else if (squash) begin          // overrides all three ops
            busy <= '0;
            done <= '0;
            head <= '0;
            tail <= '0;
        end else begin
            // retire clears first, then alloc, then completion
            for (int k = 0; k < LANES; k++) begin
                if (k < int'(rp.retire_count)) begin
                    busy[hidx[k]] <= 1'b0;
                    done[hidx[k]] <= 1'b0;
                end
            end
            for (int k = 0; k < LANES; k++) begin
                if (k < int'(ap.alloc_count)) begin
                    busy[tidx[k]] <= ap.new_entry[k].busy;
                    done[tidx[k]] <= ap.new_entry[k].done;
                end
            end
            for (int k = 0; k < LANES; k++) begin
                if (cdb_go[k]) begin
                    done[cdb_tag[k]] <= 1'b1;
                end
            end
            head <= head + TAG_W'(rp.retire_count);
            tail <= tail + TAG_W'(ap.alloc_count);
        end
    end

    always_ff @(posedge clock) begin
        if (!squash) begin
            for (int k = 0; k < LANES; k++) begin
                if (k < int'(ap.alloc_count)) begin
                    ent_reg[tidx[k]] <= ap.new_entry[k].dest_reg;
                    ent_mem[tidx[k]] <= ap.new_entry[k].is_mem;
                    ent_br[tidx[k]]  <= ap.new_entry[k].take_branch;
                    ent_val[tidx[k]] <= ap.new_entry[k].value;
                end
            end
            for (int k = 0; k < LANES; k++) begin
                if (cdb_go[k]) begin
                    ent_val[cdb_tag[k]] <= cdb_value[k];
                    ent_br[cdb_tag[k]]  <= cdb_take_branch[k];
                end
            end
        end
    end

    // window out to the retire selector
    always_comb begin
        rp.head = head;
        for (int k = 0; k < LANES; k++) begin
            rp.window[k].busy        = busy[hidx[k]];
            rp.window[k].done        = done[hidx[k]];
            rp.window[k].dest_reg    = ent_reg[hidx[k]];
            rp.window[k].is_mem      = ent_mem[hidx[k]];
            rp.window[k].take_branch = ent_br[hidx[k]];
            rp.window[k].value       = ent_val[hidx[k]];
        end
    end

    assign ap.tail = tail;

    // free slots, state after the last edge
    always_comb begin
        idle_cnt = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (!busy[i]) begin
                idle_cnt = idle_cnt + 1'b1;
            end
        end
        free_num = (idle_cnt > CNT_W'(LANES)) ? lane_cnt_t'(LANES) : lane_cnt_t'(idle_cnt);
    end

    // fetch side must respect free_num, no stall exists
    a_alloc_fits: assert property (@(posedge clock) disable iff (!arst_n)
        !squash |-> ap.alloc_count <= free_num)
        else $error("rob_table: alloc_count %0d over free_num %0d", ap.alloc_count, free_num);

    for (genvar k = 0; k < LANES; k++) begin : g_cdb_chk
        // cdb only talks about live entries
        a_cdb_busy: assert property (@(posedge clock) disable iff (!arst_n)
            (cdb_go[k] && !squash) |-> busy[cdb_tag[k]])
            else $error("rob_table: cdb lane %0d tag %0d not busy", k, cdb_tag[k]);
    end

endmodule

// ==== src/rob_retire.sv ====
`timescale 1ns/1ps

module rob_retire #(
    parameter int ROB_DEPTH = rob_pkg::DEFAULT_ROB_DEPTH,
    localparam int TAG_W    = $clog2(ROB_DEPTH)
) (
    input  logic                                  lsq_busy,   // load-store side busy

    output logic [rob_pkg::LANES-1:0]             rt_valid,
    output logic [rob_pkg::LANES-1:0][TAG_W-1:0]  rt_tag,
    output rob_pkg::reg_idx_t [rob_pkg::LANES-1:0] rt_reg,
    output rob_pkg::word_t [rob_pkg::LANES-1:0]   rt_value,
    output logic [rob_pkg::LANES-1:0]             rt_take_branch,

    retire_if.consumer                            rp
);
    import rob_pkg::*;

    // in-order selection over the window
    // mem or taken branch waits for lsq, and never follows a mem in-group
    always_comb begin
        lane_cnt_t cnt;
        logic      go;
        logic      mem_seen;
        logic      mb;
        cnt      = '0;
        go       = 1'b1;
        mem_seen = 1'b0;
        for (int k = 0; k < LANES; k++) begin
            mb          = rp.window[k].is_mem | rp.window[k].take_branch;
            go          = go & rp.window[k].done & ~((lsq_busy | mem_seen) & mb);
            rt_valid[k] = go;
            if (go) begin
                cnt = cnt + 1'b1;
            end
            mem_seen    = mem_seen | rp.window[k].is_mem;  // blocks later mb lanes
        end
        rp.retire_count = cnt;
    end

    // payload straight from the window, only meaningful under rt_valid
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            rt_tag[k]         = rp.head + TAG_W'(k);
            rt_reg[k]         = rp.window[k].dest_reg;
            rt_value[k]       = rp.window[k].value;
            rt_take_branch[k] = rp.window[k].take_branch;
        end
    end

    for (genvar k = 1; k < LANES; k++) begin : g_prefix_chk
        // no gaps in the retire group
        a_rt_prefix: assert property (@(posedge rp.clock) disable iff (!rp.arst_n)
            rt_valid[k] |-> rt_valid[k-1])
            else $error("rob_retire: lane %0d valid without lane %0d", k, k - 1);
    end

    for (genvar k = 0; k < LANES; k++) begin : g_live_chk
        // a done slot must still be allocated in the table
        a_rt_live: assert property (@(posedge rp.clock) disable iff (!rp.arst_n)
            rt_valid[k] |-> rp.window[k].busy)
            else $error("rob_retire: lane %0d retires a free slot", k);
    end

endmodule

// ==== src/rob_top.sv ====
`timescale 1ns/1ps

module rob_top #(
    parameter int ROB_DEPTH = rob_pkg::DEFAULT_ROB_DEPTH,
    localparam int TAG_W    = $clog2(ROB_DEPTH)
) (
    input  logic                                    clock,
    input  logic                                    arst_n,
    input  logic                                    squash,
    input  logic                                    lsq_busy,

    // dispatch group
    input  logic [rob_pkg::LANES-1:0]               dp_valid,
    input  logic [rob_pkg::LANES-1:0]               dp_dest_valid,
    input  logic [rob_pkg::LANES-1:0]               dp_is_mem,
    input  rob_pkg::reg_idx_t [rob_pkg::LANES-1:0]  dp_dest_reg,

    // completion
    input  logic [rob_pkg::LANES-1:0]               cdb_valid,
    input  logic [rob_pkg::LANES-1:0]               cdb_take_branch,
    input  logic [rob_pkg::LANES-1:0][TAG_W-1:0]    cdb_tag,
    input  rob_pkg::word_t [rob_pkg::LANES-1:0]     cdb_value,

    output rob_pkg::lane_cnt_t                      free_num,   // to fetch

    // map table
    output logic [rob_pkg::LANES-1:0]               mt_valid,
    output logic [rob_pkg::LANES-1:0][TAG_W-1:0]    mt_tag,
    output rob_pkg::reg_idx_t [rob_pkg::LANES-1:0]  mt_reg,

    // retire
    output logic [rob_pkg::LANES-1:0]               rt_valid,
    output logic [rob_pkg::LANES-1:0]               rt_take_branch,
    output logic [rob_pkg::LANES-1:0][TAG_W-1:0]    rt_tag,
    output rob_pkg::reg_idx_t [rob_pkg::LANES-1:0]  rt_reg,
    output rob_pkg::word_t [rob_pkg::LANES-1:0]     rt_value
);

    alloc_if  #(.ROB_DEPTH(ROB_DEPTH)) i_alloc_if ();
    retire_if #(.ROB_DEPTH(ROB_DEPTH)) i_retire_if (.clock(clock), .arst_n(arst_n));

    rob_dispatch #(.ROB_DEPTH(ROB_DEPTH)) i_rob_dispatch (
        .dp_valid       (dp_valid),
        .dp_dest_valid  (dp_dest_valid),
        .dp_dest_reg    (dp_dest_reg),
        .dp_is_mem      (dp_is_mem),
        .mt_valid       (mt_valid),
        .mt_tag         (mt_tag),
        .mt_reg         (mt_reg),
        .ap             (i_alloc_if.producer)
    );

    rob_table #(.ROB_DEPTH(ROB_DEPTH)) i_rob_table (
        .clock           (clock),
        .arst_n          (arst_n),
        .squash          (squash),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .cdb_take_branch (cdb_take_branch),
        .free_num        (free_num),
        .ap              (i_alloc_if.buffer),
        .rp              (i_retire_if.buffer)
    );

    rob_retire #(.ROB_DEPTH(ROB_DEPTH)) i_rob_retire (
        .lsq_busy        (lsq_busy),
        .rt_valid        (rt_valid),
        .rt_tag          (rt_tag),
        .rt_reg          (rt_reg),
        .rt_value        (rt_value),
        .rt_take_branch  (rt_take_branch),
        .rp              (i_retire_if.consumer)
    );

endmodule

// ==== sim/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb;
    import rob_pkg::*;

    localparam int DEPTH = 8;
    localparam int TAG_W = $clog2(DEPTH);

    logic clock;
    logic arst_n;
    logic squash;
    logic lsq_busy;
    logic [LANES-1:0] dp_valid;
    logic [LANES-1:0] dp_dest_valid;
    logic [LANES-1:0] dp_is_mem;
    reg_idx_t [LANES-1:0] dp_dest_reg;
    logic [LANES-1:0] cdb_valid;
    logic [LANES-1:0] cdb_take_branch;
    logic [LANES-1:0][TAG_W-1:0] cdb_tag;
    word_t [LANES-1:0] cdb_value;
    lane_cnt_t free_num;
    logic [LANES-1:0] mt_valid;
    logic [LANES-1:0][TAG_W-1:0] mt_tag;
    reg_idx_t [LANES-1:0] mt_reg;
    logic [LANES-1:0] rt_valid;
    logic [LANES-1:0] rt_take_branch;
    logic [LANES-1:0][TAG_W-1:0] rt_tag;
    reg_idx_t [LANES-1:0] rt_reg;
    word_t [LANES-1:0] rt_value;

    // reference model of the buffer contents
    reg_idx_t m_reg [DEPTH];
    word_t m_val [DEPTH];
    logic m_br [DEPTH];
    logic [TAG_W-1:0] exp_head;
    logic [TAG_W-1:0] exp_tail;
    int live;  // allocated, not yet retired

    int n_checks;
    int n_mismatch;
    int n_other;

    rob_top #(.ROB_DEPTH(DEPTH)) i_rob_top (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input lane_cnt_t got, input lane_cnt_t exp);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input logic [TAG_W-1:0] got,
                             input logic [TAG_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // min(free slots, lane count)
    task automatic check_free();
        int free;
        free = DEPTH - live;
        check_count("free_num", free_num, lane_cnt_t'((free > LANES) ? LANES : free));
    endtask

    function automatic logic [LANES-1:0][TAG_W-1:0] pack_tags(input logic [TAG_W-1:0] t0,
                                                              input logic [TAG_W-1:0] t1,
                                                              input logic [TAG_W-1:0] t2);
        return {t2, t1, t0};
    endfunction

    // one cycle of dispatch, map table report checked before the edge
    task automatic dispatch_group(input logic [LANES-1:0] valid, input logic [LANES-1:0] dvld,
                                  input logic [LANES-1:0] is_mem);
        int n;
        logic run;
        logic [TAG_W-1:0] t;
        n = 0;
        run = 1'b1;
        for (int i = 0; i < LANES; i++) begin
            dp_dest_reg[i] = reg_idx_t'($urandom);
        end
        dp_valid = valid;
        dp_dest_valid = dvld;
        dp_is_mem = is_mem;
        @(negedge clock);
        check_free();
        for (int i = 0; i < LANES; i++) begin
            t = exp_tail + TAG_W'(i);  // wraps at depth
            check_tag($sformatf("mt_tag[%0d]", i), mt_tag[i], t);
            check_reg($sformatf("mt_reg[%0d]", i), mt_reg[i], dvld[i] ? dp_dest_reg[i] : '0);
            check_bit($sformatf("mt_valid[%0d]", i), mt_valid[i], valid[i] & dvld[i]);
            run = run & valid[i];  // first hole ends the group
            if (run) begin
                m_reg[t] = dvld[i] ? dp_dest_reg[i] : '0;
                m_br[t] = 1'b0;
                n++;
            end
        end
        exp_tail = exp_tail + TAG_W'(n);
        live += n;
        @(posedge clock);
        #1;
        dp_valid = '0;
    endtask

    task automatic complete_group(input logic [LANES-1:0] valid,
                                  input logic [LANES-1:0][TAG_W-1:0] tags,
                                  input logic [LANES-1:0] br);
        logic run;
        run = 1'b1;
        for (int i = 0; i < LANES; i++) begin
            cdb_value[i] = word_t'($urandom);
            run = run & valid[i];
            if (run) begin
                m_val[tags[i]] = cdb_value[i];
                m_br[tags[i]] = br[i];
            end
        end
        cdb_valid = valid;
        cdb_tag = tags;
        cdb_take_branch = br;
        @(posedge clock);
        #1;
        cdb_valid = '0;
    endtask

    // waits for a retire group at the head, expects n lanes
    task automatic expect_retire(input int n);
        int waited;
        logic [TAG_W-1:0] t;
        waited = 0;
        @(negedge clock);
        while (!rt_valid[0] && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        if (!rt_valid[0]) begin
            n_other++;
            $display("ERROR t=%0t no retire from tag %0d within 20 cycles", $time, exp_head);
        end else begin
            check_free();
            for (int k = 0; k < LANES; k++) begin
                check_bit($sformatf("rt_valid[%0d]", k), rt_valid[k], k < n);
            end
            for (int k = 0; k < n; k++) begin
                t = exp_head + TAG_W'(k);
                check_tag($sformatf("rt_tag[%0d]", k), rt_tag[k], t);
                check_reg($sformatf("rt_reg[%0d]", k), rt_reg[k], m_reg[t]);
                check_word($sformatf("rt_value[%0d]", k), rt_value[k], m_val[t]);
                check_bit($sformatf("rt_take_branch[%0d]", k), rt_take_branch[k], m_br[t]);
            end
            exp_head = exp_head + TAG_W'(n);
            live -= n;
        end
        @(posedge clock);
        #1;
    endtask

    task automatic expect_no_retire(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clock);
            check_free();
            for (int k = 0; k < LANES; k++) begin
                check_bit($sformatf("rt_valid[%0d]", k), rt_valid[k], 1'b0);
            end
            @(posedge clock);
            #1;
        end
    endtask

    task automatic flush_rob();
        squash = 1'b1;
        @(posedge clock);
        #1;
        squash = 1'b0;
        exp_head = '0;
        exp_tail = '0;
        live = 0;
    endtask

    task automatic test_reset_state();
        expect_no_retire(1);                      // free_num 3, nothing retiring
        dispatch_group(3'b101, 3'b111, 3'b000);   // lane 1 hole, one entry only
        dispatch_group(3'b001, 3'b111, 3'b000);   // tail moved by one
    endtask

    task automatic test_tag_wrap();
        dispatch_group(3'b111, 3'b101, 3'b000);   // lane 1 without destination
        dispatch_group(3'b011, 3'b110, 3'b000);
        dispatch_group(3'b001, 3'b011, 3'b000);   // tail 7, tags 7 0 1
        expect_no_retire(1);                      // full
    endtask

    task automatic test_out_of_order();
        flush_rob();
        dispatch_group(3'b111, 3'b111, 3'b000);   // tags 0 1 2
        complete_group(3'b001, pack_tags(3'd2, 3'd0, 3'd0), 3'b000);
        expect_no_retire(1);                      // head still waiting
        complete_group(3'b001, pack_tags(3'd0, 3'd0, 3'd0), 3'b000);
        expect_retire(1);                         // stops at tag 1
        complete_group(3'b001, pack_tags(3'd1, 3'd0, 3'd0), 3'b000);
        expect_retire(2);
        dispatch_group(3'b111, 3'b111, 3'b000);   // tags 3 4 5
        complete_group(3'b111, pack_tags(3'd5, 3'd4, 3'd3), 3'b000);
        expect_retire(3);
    endtask

    task automatic test_lsq_hold();
        flush_rob();
        lsq_busy = 1'b1;
        dispatch_group(3'b001, 3'b001, 3'b001);   // one load at tag 0
        complete_group(3'b001, pack_tags(3'd0, 3'd0, 3'd0), 3'b000);
        expect_no_retire(2);
        lsq_busy = 1'b0;
        expect_retire(1);
        dispatch_group(3'b011, 3'b011, 3'b001);   // mem then branch
        complete_group(3'b011, pack_tags(3'd1, 3'd2, 3'd0), 3'b010);
        expect_retire(1);                         // mem leaves alone
        expect_retire(1);                         // branch next cycle
    endtask

    task automatic test_free_count();
        flush_rob();
        dispatch_group(3'b111, 3'b111, 3'b000);
        dispatch_group(3'b111, 3'b111, 3'b000);
        dispatch_group(3'b011, 3'b111, 3'b000);   // 8 of 8 used
        expect_no_retire(1);
        complete_group(3'b001, pack_tags(3'd0, 3'd0, 3'd0), 3'b000);
        expect_retire(1);
        expect_no_retire(1);                      // one slot free
        complete_group(3'b011, pack_tags(3'd1, 3'd2, 3'd0), 3'b000);
        expect_retire(2);
        expect_no_retire(1);                      // back to the cap
    endtask

    task automatic test_squash();
        squash = 1'b1;                            // dispatch and cdb in the same cycle
        dp_valid = 3'b111;
        cdb_valid = 3'b001;
        cdb_tag = pack_tags(3'd3, 3'd0, 3'd0);
        @(posedge clock);
        #1;
        squash = 1'b0;
        dp_valid = '0;
        cdb_valid = '0;
        exp_head = '0;
        exp_tail = '0;
        live = 0;
        expect_no_retire(1);
        dispatch_group(3'b001, 3'b001, 3'b000);   // restarts at tag 0
        complete_group(3'b001, pack_tags(3'd0, 3'd0, 3'd0), 3'b000);
        expect_retire(1);
    endtask

    initial begin
        void'($urandom(32'h64580898));            // one seed for the whole run
        n_checks = 0;
        n_mismatch = 0;
        n_other = 0;
        arst_n = 1'b0;
        squash = 1'b0;
        lsq_busy = 1'b0;
        dp_valid = '0;
        dp_dest_valid = '0;
        dp_is_mem = '0;
        dp_dest_reg = '0;
        cdb_valid = '0;
        cdb_take_branch = '0;
        cdb_tag = '0;
        cdb_value = '0;
        exp_head = '0;
        exp_tail = '0;
        live = 0;
        repeat (3) @(posedge clock);
        #1;
        arst_n = 1'b1;
        test_reset_state();
        test_tag_wrap();
        test_out_of_order();
        test_lsq_hold();
        test_free_count();
        test_squash();
        $display("summary: %0d checks, %0d mismatches, %0d other errors",
                 n_checks, n_mismatch, n_other);
        if (n_mismatch + n_other == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
src/rob_pkg.sv
src/rob_ifs.sv
src/rob_dispatch.sv
src/rob_table.sv
src/rob_retire.sv
src/rob_top.sv
sim/rob_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the reorder buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -sv --top-module rob_tb -f filelist.f -o rob_sim

./obj_dir/rob_sim | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "run_sim: simulation passed"
else
    echo "run_sim: simulation failed"
    exit 1
fi
